// File: src/mic_meter_pkg.sv
// ----------------------------
// Shared types, hex font and TM1638 command codes for the
// microphone level meter; imported by the RTL and the testbench
// ----------------------------

package mic_meter_pkg;

    // ----------------------------
    // Data types

    typedef logic signed [23:0] sample_t;     // Raw I2S microphone word
    typedef logic        [22:0] magnitude_t;  // Absolute value of a sample
    typedef logic        [ 7:0] segments_t;   // Bit 0 is a, bit 6 is g, bit 7 is dp
    typedef segments_t   [ 7:0] digits_t;     // Index 0 is the leftmost digit
    typedef logic        [ 7:0] leds_t;       // Bit k lights LED k

    // ----------------------------
    // TM1638 command bytes

    localparam logic [7:0] cmd_write_auto = 8'h40;  // Data write, auto increment
    localparam logic [7:0] cmd_addr_base  = 8'hC0;  // Start at display address 0
    localparam logic [7:0] cmd_display_on = 8'h8F;  // Display on, full brightness

    // ----------------------------
    // Seven segment font for one hex nibble

    function automatic segments_t hex_font(input logic [3:0] value);
        segments_t result;
        case (value)
            4'h0: result = 8'h3F;
            4'h1: result = 8'h06;
            4'h2: result = 8'h5B;
            4'h3: result = 8'h4F;
            4'h4: result = 8'h66;
            4'h5: result = 8'h6D;
            4'h6: result = 8'h7D;
            4'h7: result = 8'h07;
            4'h8: result = 8'h7F;
            4'h9: result = 8'h6F;
            4'hA: result = 8'h77;
            4'hB: result = 8'h7C;  // Lower case b
            4'hC: result = 8'h39;
            4'hD: result = 8'h5E;  // Lower case d
            4'hE: result = 8'h79;
            default: result = 8'h71;
        endcase
        return result;
    endfunction

endpackage

// File: src/inmp441_mic_i2s_receiver.sv
// ----------------------------
// I2S master for the INMP441 microphone; makes sck and ws and
// strobes out every signed 24-bit left channel sample
// ----------------------------

module inmp441_mic_i2s_receiver
    import mic_meter_pkg::*;
#(
    parameter sck_half = 1                    // clk cycles per sck half period
)
(
    input  logic    clk,
    input  logic    reset,

    output logic    sck,
    output logic    ws,
    output logic    lr,
    input  logic    sd,

    output sample_t sample,
    output logic    sample_valid
);

    localparam w_div = sck_half > 1 ? $clog2(sck_half) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               div_end;
    logic               sck_rise;
    logic               sck_fall;

    logic [5:0]         slot;                 // Bit slot within the 64 bit frame
    logic [5:0]         slot_next;
    logic               capture;

    sample_t            shift_reg;
    logic               word_done;

    assign lr        = 1'b0;                  // Left channel select
    assign div_end   = (div_cnt == w_div'(sck_half - 1));
    assign sck_rise  = div_end & ~sck;
    assign sck_fall  = div_end &  sck;
    assign slot_next = slot + 6'd1;

    // Bit 23 lands in slot 1, bit 0 in slot 24
    assign capture   = sck_rise & (slot != 6'd0) & (slot <= 6'd24);

    // ----------------------------
    // Clock generation

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            ws      <= 1'b0;
            slot    <= '0;
        end
        else
        begin
            if (div_end)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            if (div_end)
                sck <= ~sck;

            // ws and slot move on the falling edge of sck
            if (sck_fall)
            begin
                slot <= slot_next;
                ws   <= slot_next[5];             // Low for slots 0 to 31
            end
        end
    end

    // ----------------------------
    // Data capture

    always_ff @(posedge clk)
    begin
        if (capture)
            shift_reg <= {shift_reg[22:0], sd};   // MSB arrives first

        if (word_done)
            sample <= shift_reg;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            word_done    <= 1'b0;
            sample_valid <= 1'b0;
        end
        else
        begin
            word_done    <= capture & (slot == 6'd24);  // Bit 0 just shifted in
            sample_valid <= word_done;
        end
    end

endmodule

// File: src/peak_level_meter.sv
// ----------------------------
// Peak hold level meter; shows the peak magnitude as six hex
// digits plus an LED bar, cleared by holding the clear input
// ----------------------------

module peak_level_meter
    import mic_meter_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    input  sample_t sample,
    input  logic    sample_valid,
    input  logic    clear,

    output digits_t digits,
    output leds_t   leds
);

    localparam sample_t most_negative = sample_t'(24'h800000);

    magnitude_t sample_mag;
    magnitude_t peak;
    magnitude_t peak_next;

    // ----------------------------
    // Helper functions

    function automatic magnitude_t magnitude_of(input sample_t value);
        sample_t negated;
        negated = -value;
        if (!value[23])
            return value[22:0];
        else if (value == most_negative)
            return '1;                            // Saturate, -2^23 has no match
        else
            return negated[22:0];
    endfunction

    function automatic digits_t digits_of(input magnitude_t value);
        logic [23:0] wide;
        digits_t     result;
        wide = {1'b0, value};
        for (int i = 0; i < 6; i++)
            result[i] = hex_font(wide[23 - 4 * i -: 4]);  // Digit 0 is MSB
        result[6] = '0;                           // Blank
        result[7] = '0;
        return result;
    endfunction

    function automatic leds_t leds_of(input magnitude_t value);
        leds_t result;
        // LED k means peak >= 2^(15 + k)
        for (int k = 0; k < 8; k++)
            result[k] = |(value >> (15 + k));
        return result;
    endfunction

    // ----------------------------
    // Peak hold

    assign sample_mag = magnitude_of(sample);

    assign peak_next  = (clear || sample_mag > peak) ? sample_mag : peak;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            peak   <= '0;
            digits <= digits_of('0);
            leds   <= '0;
        end
        else if (sample_valid)
        begin
            // Outputs follow the new peak in the same cycle
            peak   <= peak_next;
            digits <= digits_of(peak_next);
            leds   <= leds_of(peak_next);
        end
    end

endmodule

// File: src/tm1638_board_controller.sv
// ----------------------------
// TM1638 refresh engine; sends write command, address plus
// 16 data bytes and display on, over and over
// ----------------------------

module tm1638_board_controller
    import mic_meter_pkg::*;
#(
    parameter sio_half = 4                    // clk cycles per sio_clk half period
)
(
    input  logic    clk,
    input  logic    reset,

    input  digits_t digits,
    input  leds_t   leds,

    output logic    sio_clk,
    output logic    sio_stb,
    output logic    sio_data
);

    localparam w_half = sio_half > 1 ? $clog2(sio_half) : 1;

    typedef enum logic [2:0]
    {
        st_gap,                               // Strobe high between commands
        st_cmd,
        st_addr,
        st_data,
        st_disp
    }
    state_t;

    state_t              state;
    state_t              next_step;           // Strobe to send after the gap

    logic [w_half - 1:0] half_cnt;
    logic                tick;
    logic                gap_half;

    logic [7:0]          shifter;
    logic [2:0]          bit_cnt;
    logic [3:0]          byte_cnt;
    logic [3:0]          next_index;
    logic [7:0]          next_data;
    logic                start_strobe;
    logic                bit_end;

    digits_t             frame_digits;        // Snapshot for the current frame
    leds_t               frame_leds;

    assign tick         = (half_cnt == w_half'(sio_half - 1));
    assign start_strobe = tick & (state == st_gap) & gap_half;
    assign bit_end      = tick & (state != st_gap) & sio_clk;

    // Even bytes are digit segments, odd bytes are LEDs
    assign next_index   = byte_cnt + 4'd1;
    assign next_data    = next_index[0] ? {7'b0, frame_leds[next_index[3:1]]}
                                        : frame_digits[next_index[3:1]];

    assign sio_data     = sio_stb ? 1'b1 : shifter[0];  // LSB first

    // ----------------------------
    // Sequencer

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= st_gap;
            next_step <= st_cmd;
            sio_stb   <= 1'b1;
            sio_clk   <= 1'b1;
            half_cnt  <= '0;
            gap_half  <= 1'b0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
        end
        else
        begin
            if (tick)
                half_cnt <= '0;
            else
                half_cnt <= half_cnt + 1'b1;

            if (tick && state == st_gap)
            begin
                gap_half <= ~gap_half;        // Gap lasts two half periods

                if (gap_half)
                begin
                    state   <= next_step;
                    sio_stb <= 1'b0;
                    sio_clk <= 1'b0;
                    bit_cnt <= '0;
                end
            end
            else if (tick && !sio_clk)
                sio_clk <= 1'b1;              // Rise at mid bit
            else if (bit_end && bit_cnt != 3'd7)
            begin
                sio_clk <= 1'b0;
                bit_cnt <= bit_cnt + 1'b1;
            end
            else if (bit_end)
            begin
                case (state)
                    st_addr:
                    begin
                        state    <= st_data;
                        sio_clk  <= 1'b0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                    end
                    st_data:
                        if (byte_cnt != 4'd15)
                        begin
                            byte_cnt <= byte_cnt + 1'b1;
                            sio_clk  <= 1'b0;
                            bit_cnt  <= '0;
                        end
                        else
                        begin
                            state     <= st_gap;
                            next_step <= st_disp;
                            sio_stb   <= 1'b1;
                        end
                    st_cmd:
                    begin
                        state     <= st_gap;
                        next_step <= st_addr;
                        sio_stb   <= 1'b1;
                    end
                    default:                  // Display on, frame complete
                    begin
                        state     <= st_gap;
                        next_step <= st_cmd;
                        sio_stb   <= 1'b1;
                    end
                endcase
            end
        end
    end

    // ----------------------------
    // Byte shifter and frame buffer

    always_ff @(posedge clk)
    begin
        if (start_strobe)
        begin
            case (next_step)
                st_cmd:
                begin
                    shifter      <= cmd_write_auto;
                    frame_digits <= digits;   // New frame takes fresh data
                    frame_leds   <= leds;
                end
                st_addr: shifter <= cmd_addr_base;
                default: shifter <= cmd_display_on;
            endcase
        end
        else if (bit_end)
        begin
            if (bit_cnt != 3'd7)
                shifter <= shifter >> 1;
            else if (state == st_addr)
                shifter <= frame_digits[0];
            else if (state == st_data)
                shifter <= next_data;
        end
    end

endmodule

// File: src/board_specific_top.sv
// ----------------------------
// Board top of the microphone level meter; wires the I2S
// receiver, the peak meter and the TM1638 controller together
// ----------------------------

module board_specific_top
    import mic_meter_pkg::*;
#(
    parameter clk_mhz = 50
)
(
    input  logic clk,
    input  logic reset,

    input  logic key,                         // Held high clears the peak

    output logic mic_sck,
    output logic mic_ws,
    output logic mic_lr,
    input  logic mic_sd,

    output logic sio_clk,
    output logic sio_stb,
    output logic sio_data
);

    // sck near 3 MHz, sio_clk near 1 MHz
    localparam sck_div  = (clk_mhz + 3) / 6;
    localparam sck_half = sck_div > 0 ? sck_div : 1;
    localparam sio_half = (clk_mhz + 1) / 2;

    sample_t sample;
    logic    sample_valid;
    digits_t digits;
    leds_t   leds;

    inmp441_mic_i2s_receiver
    # (
        .sck_half     ( sck_half     )
    )
    i_microphone
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .lr           ( mic_lr       ),
        .sd           ( mic_sd       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    peak_level_meter i_meter
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .clear        ( key          ),
        .digits       ( digits       ),
        .leds         ( leds         )
    );

    tm1638_board_controller
    # (
        .sio_half     ( sio_half     )
    )
    i_tm1638
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .digits       ( digits       ),
        .leds         ( leds         ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data     ( sio_data     )
    );

endmodule

// File: test/i2s_mic_model.sv
// ----------------------------
// Behavioral INMP441 microphone; sends one queued word per
// left frame on sd, or zero when nothing is queued
// ----------------------------

module i2s_mic_model
    import mic_meter_pkg::*;
(
    input  logic sck,
    input  logic ws,
    output logic sd,
    output int   words_done                   // Queued words taken by the receiver
);

    timeunit 1ns;
    timeprecision 100ps;

    sample_t pending[$];

    task automatic queue_sample(input sample_t value);
        pending.push_back(value);
    endtask

    initial
    begin
        sample_t word;
        logic    last_ws;
        logic    from_queue;
        sd         = 1'b0;
        words_done = 0;
        last_ws    = 1'b0;
        forever
        begin
            @(posedge sck);                    // ws is stable at the rising edge
            if (last_ws && !ws)
            begin
                from_queue = (pending.size() != 0);
                if (from_queue)
                    word = pending.pop_front();
                else
                    word = '0;
                // MSB first, one bit per falling edge
                for (int i = 23; i >= 0; i--)
                begin
                    @(negedge sck);
                    sd = word[i];
                end
                @(posedge sck);                // Bit 0 taken here
                if (from_queue)
                    words_done++;
            end
            last_ws = ws;
        end
    end

endmodule

// File: test/tb_board_top.sv
// ----------------------------
// Testbench of the microphone level meter; feeds I2S words and
// checks the decoded TM1638 frames against a reference model
// ----------------------------

module tb_board_top
    import mic_meter_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [15:0][7:0] frame_t;       // Byte 0 is the first data byte

    logic       clk;
    logic       reset;
    logic       key;
    logic       mic_sck;
    logic       mic_ws;
    logic       mic_lr;
    logic       mic_sd;
    logic       sio_clk;
    logic       sio_stb;
    logic       sio_data;
    int         words_done;

    sample_t    since_clear[$];              // Samples since the last clear
    frame_t     expected;
    frame_t     last_frame;
    logic [7:0] strobe_bytes[$];
    logic [7:0] shift_byte;
    logic [7:0] due_command = cmd_write_auto;
    int         bit_count     = 0;
    int         strobe_count  = 0;
    int         c0_count      = 0;
    int         compare_at    = 0;
    logic       compare_armed = 1'b0;

    board_specific_top #(.clk_mhz(8)) UUT
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .key      ( key      ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   ),
        .mic_sd   ( mic_sd   ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data )
    );

    i2s_mic_model mic
    (
        .sck        ( mic_sck    ),
        .ws         ( mic_ws     ),
        .sd         ( mic_sd     ),
        .words_done ( words_done )
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------
    // Reference and helpers

    function automatic frame_t expected_frame(input sample_t history[$]);
        int     mag;
        int     peak;
        frame_t result;
        peak = 0;
        foreach (history[n])
        begin
            mag = int'(history[n]);
            if (mag < 0)
                mag = -mag;
            if (mag > 'h7FFFFF)
                mag = 'h7FFFFF;               // -2^23 saturates
            if (mag > peak)
                peak = mag;
        end
        for (int i = 0; i < 6; i++)
            result[2 * i] = hex_font(4'((peak >> (20 - 4 * i)) & 'hF));
        result[12] = 8'h00;                   // Digits 6 and 7 blank
        result[14] = 8'h00;
        for (int k = 0; k < 8; k++)
            result[2 * k + 1] = (peak >= (1 << (15 + k))) ? 8'h01 : 8'h00;
        return result;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "first error reached");
    endtask

    task automatic check_pin(input string name, input logic got, input logic want);
        assert (got === want)
        else stop_with_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                                         name, got, want));
    endtask

    task automatic send_sample(input sample_t value, input logic with_key);
        int target;
        int waited;
        target = words_done + 1;
        key    = with_key;
        mic.queue_sample(value);
        waited = 0;
        while (words_done < target && waited < 400)
        begin
            @(negedge clk);
            waited++;
        end
        assert (words_done >= target)
        else stop_with_failure("the receiver did not take the microphone word in time");
        repeat (8) @(negedge clk);            // Meter settles before key drops
        key = 1'b0;
        if (with_key)
            since_clear.delete();
        since_clear.push_back(value);
    endtask

    task automatic expect_display(input int frames_ahead);
        int waited;
        expected      = expected_frame(since_clear);
        compare_at    = c0_count + frames_ahead;
        compare_armed = 1'b1;
        waited        = 0;
        while (compare_armed && waited < 8000)
        begin
            @(negedge clk);
            waited++;
        end
        assert (!compare_armed)
        else stop_with_failure("no address strobe with display data arrived in time");
    endtask

    task automatic wait_for_strobes(input int count);
        int waited;
        waited = 0;
        while (strobe_count < count && waited < 8000)
        begin
            @(negedge clk);
            waited++;
        end
        assert (strobe_count >= count)
        else stop_with_failure("the display on strobe did not follow the address strobe");
    endtask

    // ----------------------------
    // TM1638 frame capture

    task automatic close_strobe();
        logic [7:0] command;
        int         length;
        assert (bit_count == 0 && strobe_bytes.size() != 0)
        else stop_with_failure("a strobe ended without a whole number of bytes");
        command = strobe_bytes[0];
        assert (command == due_command)
        else stop_with_failure($sformatf("command byte 0x%02h arrived where 0x%02h was due",
                                         command, due_command));
        length = (command == cmd_addr_base) ? 17 : 1;
        assert (strobe_bytes.size() == length)
        else stop_with_failure($sformatf("strobe 0x%02h carried %0d bytes instead of %0d",
                                         command, strobe_bytes.size(), length));
        if (command == cmd_addr_base)
        begin
            for (int i = 0; i < 16; i++)
                last_frame[i] = strobe_bytes[i + 1];
            c0_count++;
        end
        case (command)
            cmd_write_auto: due_command = cmd_addr_base;
            cmd_addr_base:  due_command = cmd_display_on;
            default:        due_command = cmd_write_auto;
        endcase
        strobe_count++;
        strobe_bytes.delete();
    endtask

    always @(posedge sio_clk)
    begin
        if (!reset && !sio_stb)
        begin
            shift_byte = {sio_data, shift_byte[7:1]};  // LSB first
            bit_count++;
            if (bit_count == 8)
            begin
                strobe_bytes.push_back(shift_byte);
                bit_count = 0;
            end
        end
    end

    always @(posedge sio_stb)
    begin
        if (!reset)
            close_strobe();
    end

    // Compares the chosen data frame with the reference
    always @(c0_count)
    begin
        if (compare_armed && c0_count >= compare_at)
        begin
            for (int i = 0; i < 16; i++)
                assert (last_frame[i] == expected[i])
                else stop_with_failure($sformatf(
                    "MISMATCH sio_data byte %0d: got 0x%02h, expected 0x%02h",
                    i, last_frame[i], expected[i]));
            compare_armed = 1'b0;
        end
    end

    // ----------------------------
    // Stimulus

    initial
    begin
        int      total;
        int      group;
        sample_t value;
        logic    clear_first;
        void'($urandom(32'h46820499));
        key   = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);

        check_pin("sio_stb",  sio_stb,  1'b1);
        check_pin("sio_clk",  sio_clk,  1'b1);
        check_pin("sio_data", sio_data, 1'b1);
        check_pin("mic_sck",  mic_sck,  1'b0);
        check_pin("mic_ws",   mic_ws,   1'b0);
        check_pin("mic_lr",   mic_lr,   1'b0);
        reset = 1'b0;

        expect_display(1);                    // First frame shows zero
        wait_for_strobes(3);

        send_sample(24'h001234, 1'b0);        // Positive run
        send_sample(24'h03ABCD, 1'b0);
        send_sample(24'h000100, 1'b0);
        expect_display(2);

        send_sample(-sample_t'(24'h123456), 1'b0);
        expect_display(2);
        send_sample(sample_t'(24'h800000), 1'b0);  // Most negative
        expect_display(2);

        send_sample(24'h000042, 1'b0);        // Smaller one holds the peak
        expect_display(2);

        send_sample(-sample_t'(24'h0005A5), 1'b1);
        expect_display(2);
        send_sample(24'h000321, 1'b0);
        expect_display(2);
        send_sample(24'h00ABCD, 1'b0);
        expect_display(2);

        // Random groups with random clears
        total = 0;
        while (total < 40)
        begin
            group = $urandom_range(1, 4);
            if (group > 40 - total)
                group = 40 - total;
            clear_first = ($urandom_range(0, 2) == 0);
            for (int n = 0; n < group; n++)
            begin
                value = sample_t'($urandom) >>> $urandom_range(0, 22);
                if ($urandom_range(0, 15) == 0)
                    value = sample_t'(24'h800000);
                send_sample(value, clear_first && n == 0);
            end
            total += group;
            expect_display(2);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: list.f
src/mic_meter_pkg.sv
src/inmp441_mic_i2s_receiver.sv
src/peak_level_meter.sv
src/tm1638_board_controller.sv
src/board_specific_top.sv
test/i2s_mic_model.sv
test/tb_board_top.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --timescale 1ns/100ps -j 0
TOP   = tb_board_top
LIST  = list.f
BUILD = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(LIST)
	out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(BUILD)
